// File: cachePkg.sv
package cachePkg;

  // data word and memory beat width
  parameter int XLEN = 64;

  // request address width
  parameter int ADDR_W = 32;

  // byte offset inside a 32-byte line
  parameter int OFFSET_W = 5;

  // beats per line refill
  parameter int BEATS = 4;

  // whole line width
  parameter int LINE_W = XLEN * BEATS;

  // request FSM states
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    MISS,
    REFILL,
    RESP
  } cacheState;

endpackage

// File: cacheTagArray.sv
`timescale 1ns/1ps

module cacheTagArray #(
  parameter int NUM_SETS = 64
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        lookupEn_i,
  input  logic [cachePkg::ADDR_W-1:0] lookupAddr_i,
  input  logic                        refillDone_i,
  output logic                        hit_o,
  output logic                        hitWay_o,
  output logic [1:0]                  fillWe_o
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = cachePkg::ADDR_W - cachePkg::OFFSET_W - IDX_W;

  logic [TAG_W-1:0]    tagMem0 [NUM_SETS];
  logic [TAG_W-1:0]    tagMem1 [NUM_SETS];
  logic [NUM_SETS-1:0] valid0;
  logic [NUM_SETS-1:0] valid1;
  // index of the least recently used way in each set
  logic [NUM_SETS-1:0] lruBits;

  logic [IDX_W-1:0] lookupIdx;
  logic [IDX_W-1:0] reqIdx;
  logic [TAG_W-1:0] reqTag;
  logic [TAG_W-1:0] tagQ0;
  logic [TAG_W-1:0] tagQ1;
  logic [1:0]       validQ;
  logic             cmpValid;
  logic             hit0;
  logic             hit1;
  logic             victim;
  logic             victimQ;

  assign lookupIdx = lookupAddr_i[cachePkg::OFFSET_W +: IDX_W];

  // tag storage and the registered lookup
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      reqIdx <= lookupIdx;
      reqTag <= lookupAddr_i[cachePkg::ADDR_W-1 -: TAG_W];
      tagQ0  <= tagMem0[lookupIdx];
      tagQ1  <= tagMem1[lookupIdx];
      validQ <= {valid1[lookupIdx], valid0[lookupIdx]};
    end
    if (refillDone_i) begin
      if (victimQ) begin
        tagMem1[reqIdx] <= reqTag;
      end else begin
        tagMem0[reqIdx] <= reqTag;
      end
    end
  end

  assign hit0     = validQ[0] && (tagQ0 == reqTag);
  assign hit1     = validQ[1] && (tagQ1 == reqTag);
  // only meaningful in the cycle right after a lookup
  assign hit_o    = cmpValid && (hit0 || hit1);
  assign hitWay_o = hit1;

  // victim prefers an empty way (way0 before way1) over the LRU way
  assign victim = !validQ[0] ? 1'b0 : (!validQ[1] ? 1'b1 : lruBits[reqIdx]);

  assign fillWe_o = {refillDone_i & victimQ, refillDone_i & ~victimQ};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmpValid <= 1'b0;
      victimQ  <= 1'b0;
      valid0   <= '0;
      valid1   <= '0;
      lruBits  <= '0;
    end else begin
      cmpValid <= lookupEn_i;
      if (cmpValid && !hit_o) begin
        victimQ <= victim;
      end
      if (hit_o) begin
        lruBits[reqIdx] <= ~hit1;
      end
      if (refillDone_i) begin
        lruBits[reqIdx] <= ~victimQ;
        if (victimQ) begin
          valid1[reqIdx] <= 1'b1;
        end else begin
          valid0[reqIdx] <= 1'b1;
        end
      end
    end
  end

endmodule

// File: cacheDataWay.sv
`timescale 1ns/1ps

module cacheDataWay #(
  parameter int NUM_SETS = 64
) (
  input  logic                        clk,
  input  logic                        rdEn_i,
  input  logic [cachePkg::ADDR_W-1:0] rdIndexAddr_i,
  input  logic                        we_i,
  input  logic [cachePkg::ADDR_W-1:0] wrAddr_i,
  input  logic [cachePkg::LINE_W-1:0] wrLine_i,
  output logic [cachePkg::LINE_W-1:0] rdLine_o
);

  localparam int IDX_W = $clog2(NUM_SETS);

  logic [cachePkg::LINE_W-1:0] lineMem [NUM_SETS];
  logic [IDX_W-1:0]            rdIdx;
  logic [IDX_W-1:0]            wrIdx;

  assign rdIdx = rdIndexAddr_i[cachePkg::OFFSET_W +: IDX_W];
  assign wrIdx = wrAddr_i[cachePkg::OFFSET_W +: IDX_W];

  // one whole line per set with a registered read
  always_ff @(posedge clk) begin
    if (we_i) begin
      lineMem[wrIdx] <= wrLine_i;
    end
    if (rdEn_i) begin
      rdLine_o <= lineMem[rdIdx];
    end
  end

endmodule

// File: cacheRefill.sv
`timescale 1ns/1ps

module cacheRefill (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        refillStart_i,
  input  logic [cachePkg::ADDR_W-1:0] refillAddr_i,
  input  logic                        memRdValid_i,
  input  logic [cachePkg::XLEN-1:0]   memRdData_i,
  input  logic                        memRdLast_i,
  output logic                        memRdReq_o,
  output logic [cachePkg::ADDR_W-1:0] memAddr_o,
  output logic                        refillDone_o,
  output logic [cachePkg::LINE_W-1:0] refillLine_o
);

  logic beatTaken;

  assign beatTaken = memRdReq_o && memRdValid_i;

  // burst request held until the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memRdReq_o   <= 1'b0;
      memAddr_o    <= '0;
      refillDone_o <= 1'b0;
    end else begin
      refillDone_o <= 1'b0;
      if (refillStart_i) begin
        memRdReq_o <= 1'b1;
        memAddr_o  <= {refillAddr_i[cachePkg::ADDR_W-1:cachePkg::OFFSET_W],
                       {cachePkg::OFFSET_W{1'b0}}};
      end else if (beatTaken && memRdLast_i) begin
        memRdReq_o   <= 1'b0;
        refillDone_o <= 1'b1;
      end
    end
  end

  // lowest beat arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (beatTaken) begin
      refillLine_o <= {memRdData_i, refillLine_o[cachePkg::LINE_W-1:cachePkg::XLEN]};
    end
  end

endmodule

// File: cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl #(
  parameter int NUM_SETS = 64
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        valid_i,
  input  logic [cachePkg::ADDR_W-1:0] addr_i,
  input  logic                        hit_i,
  input  logic                        hitWay_i,
  input  logic [cachePkg::LINE_W-1:0] way0Line_i,
  input  logic [cachePkg::LINE_W-1:0] way1Line_i,
  input  logic                        refillDone_i,
  input  logic [cachePkg::LINE_W-1:0] refillLine_i,
  output logic                        addrOk_o,
  output logic                        dataOk_o,
  output logic [cachePkg::XLEN-1:0]   rdData_o,
  output logic                        lookupEn_o,
  output logic [cachePkg::ADDR_W-1:0] lookupAddr_o,
  output logic                        refillStart_o,
  output logic [cachePkg::ADDR_W-1:0] refillAddr_o
);

  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int TAG_W  = cachePkg::ADDR_W - cachePkg::OFFSET_W - IDX_W;
  localparam int WSEL_W = $clog2(cachePkg::BEATS);

  cachePkg::cacheState state;
  cachePkg::cacheState nextState;

  logic                        accept;
  logic [TAG_W-1:0]            reqTag;
  logic [IDX_W-1:0]            reqIdx;
  logic [WSEL_W-1:0]           reqWord;
  logic [cachePkg::LINE_W-1:0] srcLine;

  // new request may enter while a hit is answered
  assign addrOk_o = (state == cachePkg::IDLE) || (state == cachePkg::COMPARE && hit_i);
  assign accept   = valid_i && addrOk_o;

  assign lookupEn_o   = accept;
  assign lookupAddr_o = addr_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cachePkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::IDLE: begin
        if (accept) begin
          nextState = cachePkg::COMPARE;
        end
      end
      cachePkg::COMPARE: begin
        if (!hit_i) begin
          nextState = cachePkg::MISS;
        end else if (!accept) begin
          nextState = cachePkg::IDLE;
        end
      end
      cachePkg::MISS: begin
        nextState = cachePkg::REFILL;
      end
      cachePkg::REFILL: begin
        if (refillDone_i) begin
          nextState = cachePkg::RESP;
        end
      end
      cachePkg::RESP: begin
        nextState = cachePkg::IDLE;
      end
      default: begin
        nextState = cachePkg::IDLE;
      end
    endcase
  end

  // request fields for the compare stage and the refill
  always_ff @(posedge clk) begin
    if (accept) begin
      reqTag  <= addr_i[cachePkg::ADDR_W-1 -: TAG_W];
      reqIdx  <= addr_i[cachePkg::OFFSET_W +: IDX_W];
      reqWord <= addr_i[cachePkg::OFFSET_W-1 -: WSEL_W];
    end
  end

  assign refillStart_o = (state == cachePkg::MISS);
  assign refillAddr_o  = {reqTag, reqIdx, {cachePkg::OFFSET_W{1'b0}}};

  assign dataOk_o = (state == cachePkg::COMPARE && hit_i) || (state == cachePkg::RESP);

  // word select from the hitting way or from the fresh line in RESP
  always_comb begin
    srcLine = hitWay_i ? way1Line_i : way0Line_i;
    if (state == cachePkg::RESP) begin
      srcLine = refillLine_i;
    end
    rdData_o = srcLine[reqWord * cachePkg::XLEN +: cachePkg::XLEN];
  end

endmodule

// File: cacheTop.sv
`timescale 1ns/1ps

module cacheTop #(
  parameter int NUM_SETS = 64
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        valid_i,
  input  logic [cachePkg::ADDR_W-1:0] addr_i,
  output logic                        addrOk_o,
  output logic                        dataOk_o,
  output logic [cachePkg::XLEN-1:0]   rdData_o,
  output logic                        memRdReq_o,
  output logic [cachePkg::ADDR_W-1:0] memAddr_o,
  input  logic                        memRdValid_i,
  input  logic [cachePkg::XLEN-1:0]   memRdData_i,
  input  logic                        memRdLast_i
);

  logic                        lookupEn;
  logic [cachePkg::ADDR_W-1:0] lookupAddr;
  logic                        hit;
  logic                        hitWay;
  logic [1:0]                  fillWe;
  logic                        refillStart;
  logic [cachePkg::ADDR_W-1:0] refillAddr;
  logic                        refillDone;
  logic [cachePkg::LINE_W-1:0] refillLine;
  logic [cachePkg::LINE_W-1:0] way0Line;
  logic [cachePkg::LINE_W-1:0] way1Line;

  cacheCtrl #(
    .NUM_SETS(NUM_SETS)
  ) ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .addr_i       (addr_i),
    .hit_i        (hit),
    .hitWay_i     (hitWay),
    .way0Line_i   (way0Line),
    .way1Line_i   (way1Line),
    .refillDone_i (refillDone),
    .refillLine_i (refillLine),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .rdData_o     (rdData_o),
    .lookupEn_o   (lookupEn),
    .lookupAddr_o (lookupAddr),
    .refillStart_o(refillStart),
    .refillAddr_o (refillAddr)
  );

  cacheTagArray #(
    .NUM_SETS(NUM_SETS)
  ) tags (
    .clk         (clk),
    .rst_n       (rst_n),
    .lookupEn_i  (lookupEn),
    .lookupAddr_i(lookupAddr),
    .refillDone_i(refillDone),
    .hit_o       (hit),
    .hitWay_o    (hitWay),
    .fillWe_o    (fillWe)
  );

  // refill writes land at the latched miss address
  cacheDataWay #(
    .NUM_SETS(NUM_SETS)
  ) way0 (
    .clk          (clk),
    .rdEn_i       (lookupEn),
    .rdIndexAddr_i(lookupAddr),
    .we_i         (fillWe[0]),
    .wrAddr_i     (refillAddr),
    .wrLine_i     (refillLine),
    .rdLine_o     (way0Line)
  );

  cacheDataWay #(
    .NUM_SETS(NUM_SETS)
  ) way1 (
    .clk          (clk),
    .rdEn_i       (lookupEn),
    .rdIndexAddr_i(lookupAddr),
    .we_i         (fillWe[1]),
    .wrAddr_i     (refillAddr),
    .wrLine_i     (refillLine),
    .rdLine_o     (way1Line)
  );

  cacheRefill refill (
    .clk          (clk),
    .rst_n        (rst_n),
    .refillStart_i(refillStart),
    .refillAddr_i (refillAddr),
    .memRdValid_i (memRdValid_i),
    .memRdData_i  (memRdData_i),
    .memRdLast_i  (memRdLast_i),
    .memRdReq_o   (memRdReq_o),
    .memAddr_o    (memAddr_o),
    .refillDone_o (refillDone),
    .refillLine_o (refillLine)
  );

endmodule

// File: cacheTb_checker.sv
`timescale 1ns/1ps

module cacheProtocolChecker (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        valid_i,
  input logic [cachePkg::ADDR_W-1:0] addr_i,
  input logic                        addrOk_i,
  input logic                        dataOk_i,
  input logic                        memRdReq_i,
  input logic [cachePkg::ADDR_W-1:0] memAddr_i
);

  logic [cachePkg::ADDR_W-1:0] acceptedAddr;
  logic [cachePkg::ADDR_W-1:0] acceptedLine;

  // address of the most recent accepted request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acceptedAddr <= '0;
    end else if (valid_i && addrOk_i) begin
      acceptedAddr <= addr_i;
    end
  end

  assign acceptedLine = {acceptedAddr[cachePkg::ADDR_W-1:cachePkg::OFFSET_W],
                         {cachePkg::OFFSET_W{1'b0}}};

  // burst address held for the whole request
  addrHeld: assert property (@(posedge clk) disable iff (!rst_n)
    memRdReq_i && $past(memRdReq_i) |-> $stable(memAddr_i))
    else $error("memAddr_o changed during a burst");

  // each burst fetches the aligned line of the request that missed
  lineAddr: assert property (@(posedge clk) disable iff (!rst_n)
    memRdReq_i |-> memAddr_i == acceptedLine)
    else $error("memAddr_o is not the aligned line of the missing request");

  // back-to-back responses only for pipelined hits
  respPaced: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_i && $past(dataOk_i) |-> $past(valid_i && addrOk_i))
    else $error("dataOk_o twice without an accepted request");

  frontStalled: assert property (@(posedge clk) disable iff (!rst_n)
    memRdReq_i |-> !addrOk_i)
    else $error("addrOk_o high during a refill burst");

endmodule

bind cacheTop cacheProtocolChecker protocolCheck (
  .clk       (clk),
  .rst_n     (rst_n),
  .valid_i   (valid_i),
  .addr_i    (addr_i),
  .addrOk_i  (addrOk_o),
  .dataOk_i  (dataOk_o),
  .memRdReq_i(memRdReq_o),
  .memAddr_i (memAddr_o)
);

// File: cacheTb.sv
`timescale 1ns/1ps

module cacheTb;

  localparam int TIMEOUT = 500;

  logic                        clk;
  logic                        rst_n;
  logic                        valid_i;
  logic [cachePkg::ADDR_W-1:0] addr_i;
  logic                        addrOk_o;
  logic                        dataOk_o;
  logic [cachePkg::XLEN-1:0]   rdData_o;
  logic                        memRdReq_o;
  logic [cachePkg::ADDR_W-1:0] memAddr_o;
  logic                        memRdValid_i = 1'b0;
  logic [cachePkg::XLEN-1:0]   memRdData_i = '0;
  logic                        memRdLast_i = 1'b0;

  // memory model state
  logic [31:0]                 lfsrState = 32'h1d50_332c;
  bit                          gapsOn = 1'b0;
  bit                          reqPrev = 1'b0;
  int                          beatIdx = 0;
  int                          beatErrors = 0;
  int                          burstCount = 0;
  logic [cachePkg::ADDR_W-1:0] burstAddrs[$];

  int errCount = 0;
  int testsRun = 0;
  int testsFailed = 0;

  cacheTop cacheTop_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  // low half is the aligned byte address and high half its inverse
  function automatic logic [63:0] patternWord(input logic [31:0] addr);
    logic [31:0] aligned;
    aligned = {addr[31:3], 3'b000};
    return {~aligned, aligned};
  endfunction

  function automatic int totalErrors();
    return errCount + beatErrors;
  endfunction

  // burst-read memory giving one beat per cycle unless a gap is drawn
  always @(posedge clk) begin
    if (!rst_n) begin
      memRdValid_i <= 1'b0;
      memRdLast_i  <= 1'b0;
      reqPrev = 1'b0;
      beatIdx = 0;
    end else begin
      memRdValid_i <= 1'b0;
      memRdLast_i  <= 1'b0;
      if (memRdReq_o && !reqPrev) begin
        burstCount++;
        burstAddrs.push_back(memAddr_o);
        beatIdx = 0;
      end
      // beat shown in the last cycle is taken at this edge
      if (memRdReq_o && memRdValid_i) begin
        beatIdx++;
      end
      if (!memRdReq_o && reqPrev && beatIdx != cachePkg::BEATS) begin
        $display("[FAIL] %0t burst beats expected %0d got %0d", $time, cachePkg::BEATS, beatIdx);
        beatErrors++;
      end
      if (memRdReq_o && beatIdx < cachePkg::BEATS) begin
        if (!gapsOn || (lfsrBit() & lfsrBit())) begin
          memRdValid_i <= 1'b1;
          memRdData_i  <= patternWord(memAddr_o + 32'(beatIdx * 8));
          memRdLast_i  <= (beatIdx == cachePkg::BEATS - 1);
        end
      end
      reqPrev = memRdReq_o;
    end
  end

  task automatic flagMismatch(input string sig, input logic [63:0] exp, input logic [63:0] act);
    $display("[FAIL] %0t %s expected %h got %h", $time, sig, exp, act);
    errCount++;
  endtask

  task automatic noteTimeout(input string what);
    $display("timeout while waiting for %s", what);
    errCount++;
  endtask

  // one request from valid_i up to the dataOk_o pulse
  task automatic readOne(input logic [31:0] addr, output logic [63:0] data, output int latency);
    int t;
    valid_i <= 1'b1;
    addr_i  <= addr;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!addrOk_o && t < TIMEOUT);
    if (!addrOk_o) noteTimeout("addrOk_o");
    valid_i <= 1'b0;
    latency = 0;
    do begin
      @(posedge clk);
      latency++;
    end while (!dataOk_o && latency < TIMEOUT);
    if (!dataOk_o) noteTimeout("dataOk_o");
    data = rdData_o;
  endtask

  task automatic checkedRead(input logic [31:0] addr, input bit expectHit);
    logic [63:0] data;
    int          latency;
    int          expBursts;
    expBursts = burstCount + (expectHit ? 0 : 1);
    readOne(addr, data, latency);
    if (data !== patternWord(addr)) flagMismatch("rdData_o", patternWord(addr), data);
    if (expectHit && latency != 1) flagMismatch("hit latency", 64'(1), 64'(latency));
    if (burstCount != expBursts) flagMismatch("burst count", 64'(expBursts), 64'(burstCount));
    if (!expectHit && burstAddrs[$] !== (addr & ~32'h1f)) begin
      flagMismatch("memAddr_o", 64'(addr & ~32'h1f), 64'(burstAddrs[$]));
    end
  endtask

  task automatic reportTest(input string name, input int errsBefore);
    testsRun++;
    if (totalErrors() == errsBefore) begin
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: %0d errors", name, totalErrors() - errsBefore);
    end
  endtask

  task automatic checkResetState();
    if (addrOk_o !== 1'b1) flagMismatch("addrOk_o", 64'(1), 64'(addrOk_o));
    if (dataOk_o !== 1'b0) flagMismatch("dataOk_o", 64'(0), 64'(dataOk_o));
    if (memRdReq_o !== 1'b0) flagMismatch("memRdReq_o", 64'(0), 64'(memRdReq_o));
  endtask

  // four words of the cold-miss line at one request per cycle
  task automatic pipelinedHits();
    logic [31:0] base;
    int          sent;
    int          got;
    int          t;
    base = 32'h0000_1040;
    sent = 0;
    got  = 0;
    t    = 0;
    valid_i <= 1'b1;
    addr_i  <= base;
    while (got < 4 && t < TIMEOUT) begin
      @(posedge clk);
      t++;
      if (dataOk_o) begin
        if (rdData_o !== patternWord(base + 32'(got * 8))) begin
          flagMismatch("rdData_o", patternWord(base + 32'(got * 8)), rdData_o);
        end
        got++;
      end
      if (valid_i && addrOk_o) begin
        sent++;
        if (sent < 4) addr_i <= base + 32'(sent * 8);
        else valid_i <= 1'b0;
      end
    end
    if (got < 4) noteTimeout("pipelined dataOk_o");
    if (t != 5) flagMismatch("pipelined cycles", 64'(5), 64'(t));
  endtask

  // A, B and C share set 3
  task automatic lruEviction();
    int startBursts;
    startBursts = burstCount;
    checkedRead(32'h0001_0060, 1'b0);
    checkedRead(32'h0002_0068, 1'b0);
    checkedRead(32'h0001_0070, 1'b1);
    // B is least recently used
    checkedRead(32'h0003_0078, 1'b0);
    checkedRead(32'h0001_0060, 1'b1);
    checkedRead(32'h0002_0060, 1'b0);
    if (burstCount - startBursts != 4) begin
      flagMismatch("lru bursts", 64'(4), 64'(burstCount - startBursts));
    end
  endtask

  task automatic stalledRefills();
    gapsOn <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      checkedRead(32'h0004_0000 + 32'(i) * 32'h28, 1'b0);
    end
    gapsOn <= 1'b0;
  endtask

  initial begin
    int errsBefore;
    rst_n   = 1'b0;
    valid_i = 1'b0;
    addr_i  = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    errsBefore = totalErrors();
    checkResetState();
    reportTest("reset state", errsBefore);
    errsBefore = totalErrors();
    checkedRead(32'h0000_1048, 1'b0);
    reportTest("cold miss", errsBefore);
    errsBefore = totalErrors();
    checkedRead(32'h0000_1058, 1'b1);
    reportTest("hit timing", errsBefore);
    errsBefore = totalErrors();
    pipelinedHits();
    reportTest("pipelined hits", errsBefore);
    errsBefore = totalErrors();
    lruEviction();
    reportTest("two ways and lru", errsBefore);
    errsBefore = totalErrors();
    stalledRefills();
    reportTest("stalled refills", errsBefore);
    $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, totalErrors());
    if (totalErrors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: cacheTop.f
cachePkg.sv
cacheTagArray.sv
cacheDataWay.sv
cacheRefill.sv
cacheCtrl.sv
cacheTop.sv
cacheTb_checker.sv
cacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cacheTop.f --top-module cacheTb -o cacheSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/cacheSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation passed$" <<< "$output"; then
  exit 0
fi
exit 1
